// File: lcd_top.f
common/lcd_pkg.sv
lcd_timing/lcd_panel_table.sv
lcd_timing/lcd_scan_ctrl.sv
src/lcd_pattern_gen.sv
src/lcd_pixel_fifo.sv
src/lcd_out_stage.sv
src/lcd_top.sv
dv/lcd_checker.sv
dv/lcd_tb.sv

// File: run.sh
#!/bin/sh
# compile the lcd testbench with verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lcd_tb \
    -f lcd_top.f \
    -o lcd_sim

# the simulator exit status is not trusted here, the log decides
./obj_dir/lcd_sim 2>&1 | tee sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: dv/lcd_tb.sv
// lcd subsystem testbench
`timescale 1ns/1ps

module lcd_tb;
    import lcd_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int ROW_SLACK    = 64;   // settle cycles per row
    localparam int NUM_ROWS     = 4;

    // one test row, inputs then expected panel counts
    typedef struct packed {
        logic [15:0]          id;
        pattern_e             pat;
        logic [LCD_RGB_W-1:0] fg;
        logic [LCD_CNT_W-1:0] h_disp;
        logic [LCD_CNT_W-1:0] v_disp;
        logic [LCD_CNT_W-1:0] h_sync;
        logic [LCD_CNT_W-1:0] v_sync;
        logic [LCD_CNT_W-1:0] h_total;
        logic [LCD_CNT_W-1:0] v_total;
    } row_t;

    logic                 lcd_pclk;
    logic                 rst_n;
    logic [15:0]          lcd_id;
    pattern_e             pattern_sel;
    logic [LCD_RGB_W-1:0] fg_color;
    logic                 lcd_hs;
    logic                 lcd_vs;
    logic                 lcd_de;
    logic [LCD_RGB_W-1:0] lcd_rgb;
    logic                 frame_start;
    logic [LCD_CNT_W-1:0] h_disp;
    logic [LCD_CNT_W-1:0] v_disp;
    logic                 underrun;

    row_t rows [NUM_ROWS];
    logic rows_ready;   // table filled, watchdog may size itself
    int   errors;

    lcd_top i_lcd_top (
        .lcd_pclk    (lcd_pclk),
        .rst_n       (rst_n),
        .lcd_id      (lcd_id),
        .pattern_sel (pattern_sel),
        .fg_color    (fg_color),
        .lcd_hs      (lcd_hs),
        .lcd_vs      (lcd_vs),
        .lcd_de      (lcd_de),
        .lcd_rgb     (lcd_rgb),
        .frame_start (frame_start),
        .h_disp      (h_disp),
        .v_disp      (v_disp),
        .underrun    (underrun)
    );

    always #(CLK_PERIOD / 2) lcd_pclk = ~lcd_pclk;

    // ----------------------------------------------------------------------
    // reference model and compare tasks
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // pixel expected at active position x, y
    function automatic logic [LCD_RGB_W-1:0] pixel_model(input pattern_e pat,
                                                         input logic [LCD_RGB_W-1:0] fg,
                                                         input int x, input int y);
        logic inv;
        inv = ((x >> 4) & 1) != ((y >> 4) & 1);   // 16 pixel squares
        case (pat)
            PAT_SOLID: return fg;
            PAT_HGRAD: return LCD_RGB_W'(x);
            PAT_VGRAD: return LCD_RGB_W'(y);
            default:   return inv ? ~fg : fg;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_count(input logic [LCD_CNT_W-1:0] got,
                               input logic [LCD_CNT_W-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_pixel(input logic [LCD_RGB_W-1:0] got,
                               input logic [LCD_RGB_W-1:0] exp,
                               input string what, input int x, input int y);
        if (got !== exp) begin
            errors++;
            abort_run($sformatf("mismatch at %0t: %s at x %0d y %0d is %h, expected %h",
                                $time, what, x, y, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // one row: reset, wait for a frame, check the next full frame
    // ----------------------------------------------------------------------
    task automatic run_row(input int r);
        int   x;
        int   y;
        int   cycles;
        int   de_run;
        int   de_lines;
        int   hs_run;
        int   hs_lines;
        int   vs_run;
        logic prev_de;
        logic prev_hs;
        logic prev_vs;
        logic vs_seen;

        @(negedge lcd_pclk);
        rst_n       = 1'b0;
        lcd_id      = rows[r].id;
        pattern_sel = rows[r].pat;
        fg_color    = rows[r].fg;
        repeat (RESET_CYCLES) @(negedge lcd_pclk);
        rst_n = 1'b1;
        repeat (2) @(negedge lcd_pclk);   // table registers the id
        check_count(h_disp, rows[r].h_disp, "h_disp");
        check_count(v_disp, rows[r].v_disp, "v_disp");

        while (frame_start !== 1'b1) @(negedge lcd_pclk);

        x        = 0;
        y        = 0;
        cycles   = 0;
        de_run   = 0;
        de_lines = 0;
        hs_run   = 0;
        hs_lines = 0;
        vs_run   = 0;
        vs_seen  = 1'b0;
        prev_de  = lcd_de;
        prev_hs  = lcd_hs;
        prev_vs  = lcd_vs;

        // pins lag frame_start by one cycle, so this covers the frame exactly
        do begin
            @(negedge lcd_pclk);
            cycles++;
            if (lcd_de === 1'b1) begin
                check_pixel(lcd_rgb, pixel_model(rows[r].pat, rows[r].fg, x, y),
                            "lcd_rgb", x, y);
                x++;
                de_run++;
            end else begin
                check_pixel(lcd_rgb, '0, "blanked lcd_rgb", x, y);
                if (prev_de === 1'b1) begin   // end of an active line
                    check_count(LCD_CNT_W'(de_run), rows[r].h_disp, "de cycles in a line");
                    de_lines++;
                    de_run = 0;
                    x      = 0;
                    y++;
                end
            end
            if (lcd_hs === 1'b0) begin
                hs_run++;
            end else if (prev_hs === 1'b0) begin
                check_count(LCD_CNT_W'(hs_run), rows[r].h_sync, "hs low cycles");
                hs_run = 0;
                hs_lines++;
            end
            if (lcd_vs === 1'b0) begin
                vs_run++;
            end else if (prev_vs === 1'b0) begin
                check_count(LCD_CNT_W'(vs_run % int'(rows[r].h_total)), '0,
                            "vs low cycles modulo h_total");
                check_count(LCD_CNT_W'(vs_run / int'(rows[r].h_total)), rows[r].v_sync,
                            "vs low lines");
                vs_seen = 1'b1;
            end
            check_flag(underrun, 1'b0, "underrun");
            prev_de = lcd_de;
            prev_hs = lcd_hs;
            prev_vs = lcd_vs;
        end while (frame_start !== 1'b1);

        check_count(LCD_CNT_W'(de_lines), rows[r].v_disp, "active lines per frame");
        check_count(LCD_CNT_W'(hs_lines), rows[r].v_total, "hs pulses per frame");
        check_flag(vs_seen, 1'b1, "vs pulse seen in frame");
        check_count(LCD_CNT_W'(cycles / int'(rows[r].v_total)), rows[r].h_total,
                    "frame_start period over v_total");
        check_count(LCD_CNT_W'(cycles % int'(rows[r].v_total)), '0,
                    "frame_start period modulo v_total");
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [31:0] seed;

        lcd_pclk    = 1'b0;
        rst_n       = 1'b0;
        lcd_id      = '0;
        pattern_sel = PAT_SOLID;
        fg_color    = '0;
        errors      = 0;
        rows_ready  = 1'b0;

        rows[0] = '{LCD_ID_4342, PAT_CHECKER, 16'h0, H_DISP_4342, V_DISP_4342,
                    H_SYNC_4342, V_SYNC_4342, H_TOTAL_4342, V_TOTAL_4342};
        rows[1] = '{LCD_ID_7084, PAT_HGRAD, 16'h0, H_DISP_7084, V_DISP_7084,
                    H_SYNC_7084, V_SYNC_7084, H_TOTAL_7084, V_TOTAL_7084};
        rows[2] = '{LCD_ID_1018, PAT_SOLID, 16'h0, H_DISP_1018, V_DISP_1018,
                    H_SYNC_1018, V_SYNC_1018, H_TOTAL_1018, V_TOTAL_1018};
        rows[3] = '{16'h1234, PAT_VGRAD, 16'h0, H_DISP_4342, V_DISP_4342,   // unknown id
                    H_SYNC_4342, V_SYNC_4342, H_TOTAL_4342, V_TOTAL_4342};
        seed = 32'd78097;
        for (int r = 0; r < NUM_ROWS; r++) begin
            seed       = lcg_next(seed);
            rows[r].fg = seed[31:16];   // upper bits, better spread
        end
        rows_ready = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("checks failed during the run");
        end
    end

    // two frames per row plus reset and settle time
    initial begin : watchdog
        longint budget;
        wait (rows_ready === 1'b1);
        budget = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            budget += 2 * longint'(rows[r].h_total) * longint'(rows[r].v_total)
                      + RESET_CYCLES + ROW_SLACK;
        end
        #(budget * CLK_PERIOD);
        abort_run($sformatf("timeout: the frames did not finish within %0d clock cycles",
                            budget));
    end

endmodule

// File: dv/lcd_checker.sv
// lcd protocol assertions
`timescale 1ns/1ps

module lcd_checker (
    input  logic                             lcd_pclk,
    input  logic                             rst_n,
    input  logic                             lcd_de,
    input  logic [lcd_pkg::LCD_RGB_W-1:0]    lcd_rgb,
    input  logic                             underrun,
    input  logic                             push,
    input  logic [lcd_pkg::LCD_CREDIT_W-1:0] credit_cnt    // generator side credits
);
    import lcd_pkg::*;

    // blanking outside active video
    a_rgb_blank: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        !lcd_de |-> (lcd_rgb == '0))
        else $error("lcd_rgb is not zero while lcd_de is low");

    // fifo must never run dry
    a_no_underrun: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        !underrun)
        else $error("pixel fifo underrun flag is set");

    // ----------------------------------------------------------------------
    // credit flow control
    // ----------------------------------------------------------------------
    a_credit_range: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        credit_cnt <= LCD_FIFO_DEPTH)
        else $error("credit counter above fifo depth");

    a_push_credit: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        push |-> (credit_cnt != '0))
        else $error("push issued without a credit");

endmodule

bind lcd_top lcd_checker i_lcd_checker (
    .lcd_pclk   (lcd_pclk),
    .rst_n      (rst_n),
    .lcd_de     (lcd_de),
    .lcd_rgb    (lcd_rgb),
    .underrun   (underrun),
    .push       (push),
    .credit_cnt (i_pattern_gen.credit_cnt)
);

// File: src/lcd_top.sv
// rgb lcd subsystem top
`timescale 1ns/1ps

module lcd_top (
    input  logic                          lcd_pclk,
    input  logic                          rst_n,
    input  logic [15:0]                   lcd_id,
    input  lcd_pkg::pattern_e             pattern_sel,
    input  logic [lcd_pkg::LCD_RGB_W-1:0] fg_color,
    output logic                          lcd_hs,
    output logic                          lcd_vs,
    output logic                          lcd_de,
    output logic [lcd_pkg::LCD_RGB_W-1:0] lcd_rgb,
    output logic                          frame_start,
    output logic [lcd_pkg::LCD_CNT_W-1:0] h_disp,
    output logic [lcd_pkg::LCD_CNT_W-1:0] v_disp,
    output logic                          underrun
);
    import lcd_pkg::*;

    // panel timing
    logic [LCD_CNT_W-1:0] h_sync;
    logic [LCD_CNT_W-1:0] h_back;
    logic [LCD_CNT_W-1:0] h_total;
    logic [LCD_CNT_W-1:0] v_sync;
    logic [LCD_CNT_W-1:0] v_back;
    logic [LCD_CNT_W-1:0] v_total;
    // scan to output stage
    logic                 pix_req;
    logic                 scan_hs;
    logic                 scan_vs;
    // pixel path
    logic                 push;
    logic [LCD_RGB_W-1:0] push_data;
    logic                 credit_ret;
    logic [LCD_RGB_W-1:0] pop_data;
    logic                 empty;

    lcd_panel_table i_panel_table (
        .lcd_pclk (lcd_pclk),
        .rst_n    (rst_n),
        .lcd_id   (lcd_id),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .h_disp   (h_disp),
        .h_total  (h_total),
        .v_sync   (v_sync),
        .v_back   (v_back),
        .v_disp   (v_disp),
        .v_total  (v_total)
    );

    lcd_scan_ctrl i_scan_ctrl (
        .lcd_pclk    (lcd_pclk),
        .rst_n       (rst_n),
        .h_sync      (h_sync),
        .h_back      (h_back),
        .h_disp      (h_disp),
        .h_total     (h_total),
        .v_sync      (v_sync),
        .v_back      (v_back),
        .v_disp      (v_disp),
        .v_total     (v_total),
        .lcd_hs      (scan_hs),
        .lcd_vs      (scan_vs),
        .frame_start (frame_start),
        .pix_req     (pix_req)
    );

    lcd_pattern_gen i_pattern_gen (
        .lcd_pclk    (lcd_pclk),
        .rst_n       (rst_n),
        .pattern_sel (pattern_sel),
        .fg_color    (fg_color),
        .h_disp      (h_disp),
        .v_disp      (v_disp),
        .credit_ret  (credit_ret),
        .push        (push),
        .push_data   (push_data)
    );

    lcd_pixel_fifo i_pixel_fifo (
        .lcd_pclk   (lcd_pclk),
        .rst_n      (rst_n),
        .push       (push),
        .push_data  (push_data),
        .pop        (pix_req),      // each request takes one pixel
        .pop_data   (pop_data),
        .empty      (empty),
        .credit_ret (credit_ret)
    );

    lcd_out_stage i_out_stage (
        .lcd_pclk (lcd_pclk),
        .rst_n    (rst_n),
        .pix_req  (pix_req),
        .pop_data (pop_data),
        .empty    (empty),
        .hs_in    (scan_hs),
        .vs_in    (scan_vs),
        .lcd_de   (lcd_de),
        .lcd_rgb  (lcd_rgb),
        .lcd_hs   (lcd_hs),
        .lcd_vs   (lcd_vs),
        .underrun (underrun)
    );

endmodule

// File: src/lcd_out_stage.sv
// lcd pin output register
`timescale 1ns/1ps

module lcd_out_stage (
    input  logic                          lcd_pclk,
    input  logic                          rst_n,
    input  logic                          pix_req,
    input  logic [lcd_pkg::LCD_RGB_W-1:0] pop_data,
    input  logic                          empty,
    input  logic                          hs_in,
    input  logic                          vs_in,
    output logic                          lcd_de,
    output logic [lcd_pkg::LCD_RGB_W-1:0] lcd_rgb,
    output logic                          lcd_hs,
    output logic                          lcd_vs,
    output logic                          underrun   // sticky until reset
);
    import lcd_pkg::*;

    // every pin one cycle behind the scan counters
    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_de   <= 1'b0;
            lcd_rgb  <= '0;
            lcd_hs   <= 1'b0;
            lcd_vs   <= 1'b0;
            underrun <= 1'b0;
        end else begin
            lcd_de   <= pix_req;
            lcd_hs   <= hs_in;
            lcd_vs   <= vs_in;
            // blank outside active video and on a missing pixel
            lcd_rgb  <= (pix_req && !empty) ? pop_data : {LCD_RGB_W{1'b0}};
            underrun <= underrun || (pix_req && empty);
        end
    end

endmodule

// File: src/lcd_pixel_fifo.sv
// pixel fifo with credit return
`timescale 1ns/1ps

module lcd_pixel_fifo (
    input  logic                          lcd_pclk,
    input  logic                          rst_n,
    input  logic                          push,
    input  logic [lcd_pkg::LCD_RGB_W-1:0] push_data,
    input  logic                          pop,
    output logic [lcd_pkg::LCD_RGB_W-1:0] pop_data,   // head word, valid when !empty
    output logic                          empty,
    output logic                          credit_ret
);
    import lcd_pkg::*;

    logic [LCD_RGB_W-1:0]    mem [LCD_FIFO_DEPTH];
    logic [LCD_PTR_W-1:0]    wr_ptr;
    logic [LCD_PTR_W-1:0]    rd_ptr;
    logic [LCD_CREDIT_W-1:0] count;   // occupancy, 0..depth
    logic                    pop_ok;

    assign empty      = (count == '0);
    assign pop_ok     = pop && !empty;   // empty pop is dropped
    assign pop_data   = mem[rd_ptr];
    assign credit_ret = pop_ok;          // same cycle as the pop

    // storage, no room check since the sender holds credits
    always_ff @(posedge lcd_pclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // power of two depth wraps
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + LCD_CREDIT_W'(push) - LCD_CREDIT_W'(pop_ok);
        end
    end

endmodule

// File: src/lcd_pattern_gen.sv
// raster test pattern source
`timescale 1ns/1ps

module lcd_pattern_gen (
    input  logic                          lcd_pclk,
    input  logic                          rst_n,
    input  lcd_pkg::pattern_e             pattern_sel,
    input  logic [lcd_pkg::LCD_RGB_W-1:0] fg_color,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] h_disp,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] v_disp,
    input  logic                          credit_ret,   // one per fifo pop
    output logic                          push,
    output logic [lcd_pkg::LCD_RGB_W-1:0] push_data
);
    import lcd_pkg::*;

    logic [LCD_CREDIT_W-1:0] credit_cnt;   // free fifo slots as seen here
    logic                    go;           // set one cycle after reset
    logic [LCD_CNT_W-1:0]    x;
    logic [LCD_CNT_W-1:0]    y;
    logic [LCD_RGB_W-1:0]    x_ext;
    logic [LCD_RGB_W-1:0]    y_ext;

    // start once the table holds the panel sizes
    assign push  = go && (credit_cnt != '0);
    assign x_ext = {{(LCD_RGB_W-LCD_CNT_W){1'b0}}, x};
    assign y_ext = {{(LCD_RGB_W-LCD_CNT_W){1'b0}}, y};

    // pixel at the current raster position
    always_comb begin
        case (pattern_sel)
            PAT_SOLID:   push_data = fg_color;
            PAT_HGRAD:   push_data = x_ext;
            PAT_VGRAD:   push_data = y_ext;
            default:     push_data = (x[4] ^ y[4]) ? ~fg_color : fg_color;   // checker
        endcase
    end

    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            go         <= 1'b0;
            credit_cnt <= LCD_CREDIT_W'(LCD_FIFO_DEPTH);   // fifo starts empty
            x          <= '0;
            y          <= '0;
        end else begin
            go         <= 1'b1;
            // push and return together cancel out
            credit_cnt <= credit_cnt - LCD_CREDIT_W'(push) + LCD_CREDIT_W'(credit_ret);
            if (push) begin
                if (x == h_disp - 1'b1) begin
                    x <= '0;
                    y <= (y == v_disp - 1'b1) ? '0 : y + 1'b1;   // frame wrap
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

endmodule

// File: lcd_timing/lcd_scan_ctrl.sv
// lcd scan controller
`timescale 1ns/1ps

module lcd_scan_ctrl (
    input  logic                          lcd_pclk,
    input  logic                          rst_n,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] h_sync,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] h_back,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] h_disp,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] h_total,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] v_sync,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] v_back,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] v_disp,
    input  logic [lcd_pkg::LCD_CNT_W-1:0] v_total,
    output logic                          lcd_hs,        // low during h sync
    output logic                          lcd_vs,        // low during v sync
    output logic                          frame_start,   // h_cnt = 0, v_cnt = 0
    output logic                          pix_req        // one pixel pop per active cycle
);
    import lcd_pkg::*;

    logic [LCD_CNT_W-1:0] h_cnt;
    logic [LCD_CNT_W-1:0] v_cnt;
    logic [LCD_CNT_W-1:0] ph_cnt;   // position inside current line phase
    logic [LCD_CNT_W-1:0] h_nxt;
    logic [LCD_CNT_W-1:0] v_nxt;
    logic [LCD_CNT_W-1:0] ph_len;   // length of current phase
    scan_state_e          h_state;
    scan_state_e          h_state_nxt;
    logic                 h_wrap;
    logic                 ph_end;
    logic                 v_act;    // v_cnt inside active lines
    logic                 v_act_nxt;

    // ----------------------------------------------------------------------
    // counter next values
    // ----------------------------------------------------------------------
    always_comb begin
        h_wrap = (h_cnt == h_total - 1'b1);
        h_nxt  = h_wrap ? '0 : h_cnt + 1'b1;
        v_nxt  = v_cnt;
        if (h_wrap) begin
            v_nxt = (v_cnt == v_total - 1'b1) ? '0 : v_cnt + 1'b1;
        end
    end

    // vertical window only looked at on the line wrap
    always_comb begin
        v_act_nxt = v_act;
        if (h_wrap) begin
            v_act_nxt = (v_nxt >= v_sync + v_back) && (v_nxt < v_sync + v_back + v_disp);
        end
    end

    // ----------------------------------------------------------------------
    // line state, steps on phase length instead of h_cnt sums
    // ----------------------------------------------------------------------
    always_comb begin
        case (h_state)
            S_SYNC:  ph_len = h_sync;
            S_BACK:  ph_len = h_back;
            default: ph_len = h_disp;
        endcase
        ph_end = (h_state != S_FRONT) && (ph_cnt == ph_len - 1'b1);

        h_state_nxt = h_state;
        if (h_wrap) begin
            h_state_nxt = S_SYNC;          // front porch ends on the wrap
        end else if (ph_end) begin
            case (h_state)
                S_SYNC:  h_state_nxt = S_BACK;
                S_BACK:  h_state_nxt = S_ACTIVE;
                default: h_state_nxt = S_FRONT;
            endcase
        end
    end

    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            ph_cnt      <= '0;
            h_state     <= S_SYNC;
            v_act       <= 1'b0;
            lcd_hs      <= 1'b0;   // counters start inside sync
            lcd_vs      <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            h_cnt       <= h_nxt;
            v_cnt       <= v_nxt;
            ph_cnt      <= (h_wrap || ph_end) ? '0 : ph_cnt + 1'b1;
            h_state     <= h_state_nxt;
            v_act       <= v_act_nxt;
            // registered from next values, so in step with the counters
            lcd_hs      <= (h_state_nxt != S_SYNC);
            lcd_vs      <= (v_nxt >= v_sync);
            frame_start <= (h_nxt == '0) && (v_nxt == '0);
        end
    end

    assign pix_req = (h_state == S_ACTIVE) && v_act;

endmodule

// File: lcd_timing/lcd_panel_table.sv
// panel timing lookup
`timescale 1ns/1ps

module lcd_panel_table (
    input  logic                          lcd_pclk,
    input  logic                          rst_n,
    input  logic [15:0]                   lcd_id,
    output logic [lcd_pkg::LCD_CNT_W-1:0] h_sync,
    output logic [lcd_pkg::LCD_CNT_W-1:0] h_back,
    output logic [lcd_pkg::LCD_CNT_W-1:0] h_disp,
    output logic [lcd_pkg::LCD_CNT_W-1:0] h_total,
    output logic [lcd_pkg::LCD_CNT_W-1:0] v_sync,
    output logic [lcd_pkg::LCD_CNT_W-1:0] v_back,
    output logic [lcd_pkg::LCD_CNT_W-1:0] v_disp,
    output logic [lcd_pkg::LCD_CNT_W-1:0] v_total
);
    import lcd_pkg::*;

    logic [8*LCD_CNT_W-1:0] set_nxt;   // packed h/v sync, back, disp, total
    logic [8*LCD_CNT_W-1:0] set_q;

    // id decode
    always_comb begin
        case (lcd_id)
            LCD_ID_4342: set_nxt = LCD_SET_4342;
            LCD_ID_7084: set_nxt = {H_SYNC_7084, H_BACK_7084, H_DISP_7084, H_TOTAL_7084,
                                    V_SYNC_7084, V_BACK_7084, V_DISP_7084, V_TOTAL_7084};
            LCD_ID_7016: set_nxt = {H_SYNC_7016, H_BACK_7016, H_DISP_7016, H_TOTAL_7016,
                                    V_SYNC_7016, V_BACK_7016, V_DISP_7016, V_TOTAL_7016};
            LCD_ID_4384: set_nxt = {H_SYNC_4384, H_BACK_4384, H_DISP_4384, H_TOTAL_4384,
                                    V_SYNC_4384, V_BACK_4384, V_DISP_4384, V_TOTAL_4384};
            LCD_ID_1018: set_nxt = {H_SYNC_1018, H_BACK_1018, H_DISP_1018, H_TOTAL_1018,
                                    V_SYNC_1018, V_BACK_1018, V_DISP_1018, V_TOTAL_1018};
            default:     set_nxt = LCD_SET_4342;   // unknown panel
        endcase
    end

    // one cycle behind lcd_id, 4342 timing out of reset
    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            set_q <= LCD_SET_4342;
        end else begin
            set_q <= set_nxt;
        end
    end

    assign {h_sync, h_back, h_disp, h_total, v_sync, v_back, v_disp, v_total} = set_q;

endmodule

// File: common/lcd_pkg.sv
// lcd subsystem shared definitions
package lcd_pkg;

    // ----------------------------------------------------------------------
    // widths and fifo sizing
    // ----------------------------------------------------------------------
    localparam int LCD_CNT_W      = 11;                           // timing counts, positions
    localparam int LCD_RGB_W      = 16;                           // rgb565
    localparam int LCD_FIFO_DEPTH = 4;                            // power of two, >= 2
    localparam int LCD_CREDIT_W   = $clog2(LCD_FIFO_DEPTH + 1);   // holds full depth
    localparam int LCD_PTR_W      = $clog2(LCD_FIFO_DEPTH);       // fifo pointer

    // panel id codes as read from the panel
    localparam logic [15:0] LCD_ID_4342 = 16'h4342;
    localparam logic [15:0] LCD_ID_7084 = 16'h7084;
    localparam logic [15:0] LCD_ID_7016 = 16'h7016;
    localparam logic [15:0] LCD_ID_4384 = 16'h4384;
    localparam logic [15:0] LCD_ID_1018 = 16'h1018;

    // ----------------------------------------------------------------------
    // panel timing, total = sync + back + disp + front
    // ----------------------------------------------------------------------
    // 4.3" 480x272
    localparam logic [LCD_CNT_W-1:0] H_SYNC_4342  = 11'd41;
    localparam logic [LCD_CNT_W-1:0] H_BACK_4342  = 11'd2;
    localparam logic [LCD_CNT_W-1:0] H_DISP_4342  = 11'd480;
    localparam logic [LCD_CNT_W-1:0] H_FRONT_4342 = 11'd2;
    localparam logic [LCD_CNT_W-1:0] H_TOTAL_4342 = H_SYNC_4342 + H_BACK_4342 + H_DISP_4342
                                                    + H_FRONT_4342;   // 525
    localparam logic [LCD_CNT_W-1:0] V_SYNC_4342  = 11'd10;
    localparam logic [LCD_CNT_W-1:0] V_BACK_4342  = 11'd2;
    localparam logic [LCD_CNT_W-1:0] V_DISP_4342  = 11'd272;
    localparam logic [LCD_CNT_W-1:0] V_FRONT_4342 = 11'd2;
    localparam logic [LCD_CNT_W-1:0] V_TOTAL_4342 = V_SYNC_4342 + V_BACK_4342 + V_DISP_4342
                                                    + V_FRONT_4342;   // 286
    // 7" 800x480
    localparam logic [LCD_CNT_W-1:0] H_SYNC_7084  = 11'd128;
    localparam logic [LCD_CNT_W-1:0] H_BACK_7084  = 11'd88;
    localparam logic [LCD_CNT_W-1:0] H_DISP_7084  = 11'd800;
    localparam logic [LCD_CNT_W-1:0] H_FRONT_7084 = 11'd40;
    localparam logic [LCD_CNT_W-1:0] H_TOTAL_7084 = H_SYNC_7084 + H_BACK_7084 + H_DISP_7084
                                                    + H_FRONT_7084;   // 1056
    localparam logic [LCD_CNT_W-1:0] V_SYNC_7084  = 11'd2;
    localparam logic [LCD_CNT_W-1:0] V_BACK_7084  = 11'd33;
    localparam logic [LCD_CNT_W-1:0] V_DISP_7084  = 11'd480;
    localparam logic [LCD_CNT_W-1:0] V_FRONT_7084 = 11'd10;
    localparam logic [LCD_CNT_W-1:0] V_TOTAL_7084 = V_SYNC_7084 + V_BACK_7084 + V_DISP_7084
                                                    + V_FRONT_7084;   // 525
    // 7" 1024x600
    localparam logic [LCD_CNT_W-1:0] H_SYNC_7016  = 11'd20;
    localparam logic [LCD_CNT_W-1:0] H_BACK_7016  = 11'd140;
    localparam logic [LCD_CNT_W-1:0] H_DISP_7016  = 11'd1024;
    localparam logic [LCD_CNT_W-1:0] H_FRONT_7016 = 11'd160;
    localparam logic [LCD_CNT_W-1:0] H_TOTAL_7016 = H_SYNC_7016 + H_BACK_7016 + H_DISP_7016
                                                    + H_FRONT_7016;   // 1344
    localparam logic [LCD_CNT_W-1:0] V_SYNC_7016  = 11'd3;
    localparam logic [LCD_CNT_W-1:0] V_BACK_7016  = 11'd20;
    localparam logic [LCD_CNT_W-1:0] V_DISP_7016  = 11'd600;
    localparam logic [LCD_CNT_W-1:0] V_FRONT_7016 = 11'd12;
    localparam logic [LCD_CNT_W-1:0] V_TOTAL_7016 = V_SYNC_7016 + V_BACK_7016 + V_DISP_7016
                                                    + V_FRONT_7016;   // 635
    // 4.3" 800x480, same timing as the 7" 800x480
    localparam logic [LCD_CNT_W-1:0] H_SYNC_4384  = H_SYNC_7084;
    localparam logic [LCD_CNT_W-1:0] H_BACK_4384  = H_BACK_7084;
    localparam logic [LCD_CNT_W-1:0] H_DISP_4384  = H_DISP_7084;
    localparam logic [LCD_CNT_W-1:0] H_FRONT_4384 = H_FRONT_7084;
    localparam logic [LCD_CNT_W-1:0] H_TOTAL_4384 = H_SYNC_4384 + H_BACK_4384 + H_DISP_4384
                                                    + H_FRONT_4384;
    localparam logic [LCD_CNT_W-1:0] V_SYNC_4384  = V_SYNC_7084;
    localparam logic [LCD_CNT_W-1:0] V_BACK_4384  = V_BACK_7084;
    localparam logic [LCD_CNT_W-1:0] V_DISP_4384  = V_DISP_7084;
    localparam logic [LCD_CNT_W-1:0] V_FRONT_4384 = V_FRONT_7084;
    localparam logic [LCD_CNT_W-1:0] V_TOTAL_4384 = V_SYNC_4384 + V_BACK_4384 + V_DISP_4384
                                                    + V_FRONT_4384;
    // 10.1" 1280x800
    localparam logic [LCD_CNT_W-1:0] H_SYNC_1018  = 11'd10;
    localparam logic [LCD_CNT_W-1:0] H_BACK_1018  = 11'd80;
    localparam logic [LCD_CNT_W-1:0] H_DISP_1018  = 11'd1280;
    localparam logic [LCD_CNT_W-1:0] H_FRONT_1018 = 11'd70;
    localparam logic [LCD_CNT_W-1:0] H_TOTAL_1018 = H_SYNC_1018 + H_BACK_1018 + H_DISP_1018
                                                    + H_FRONT_1018;   // 1440
    localparam logic [LCD_CNT_W-1:0] V_SYNC_1018  = 11'd3;
    localparam logic [LCD_CNT_W-1:0] V_BACK_1018  = 11'd10;
    localparam logic [LCD_CNT_W-1:0] V_DISP_1018  = 11'd800;
    localparam logic [LCD_CNT_W-1:0] V_FRONT_1018 = 11'd10;
    localparam logic [LCD_CNT_W-1:0] V_TOTAL_1018 = V_SYNC_1018 + V_BACK_1018 + V_DISP_1018
                                                    + V_FRONT_1018;   // 823

    // fallback set, also the reset value of the table
    localparam logic [8*LCD_CNT_W-1:0] LCD_SET_4342 = {H_SYNC_4342, H_BACK_4342, H_DISP_4342,
                                                       H_TOTAL_4342, V_SYNC_4342, V_BACK_4342,
                                                       V_DISP_4342, V_TOTAL_4342};

    // ----------------------------------------------------------------------
    // enums
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        PAT_SOLID,      // fg_color everywhere
        PAT_HGRAD,      // rgb = x
        PAT_VGRAD,      // rgb = y
        PAT_CHECKER     // 16x16 squares, fg and ~fg
    } pattern_e;

    typedef enum logic [1:0] {
        S_SYNC,
        S_BACK,
        S_ACTIVE,
        S_FRONT
    } scan_state_e;

endpackage
